// File: exu_pkg.sv
package exu_pkg;

    localparam int xlen       = 32;
    localparam int mul_slice  = 8;                  // op2 bits retired per pass
    localparam int mul_steps  = xlen / mul_slice;   // 4 passes
    localparam int mul_step_w = $clog2(mul_steps);

    // operation codes, grouped as in the decoder
    typedef enum logic [5:0] {
        op_add    = 6'b000000,  // alt selects sub
        op_sll    = 6'b000001,
        op_sr     = 6'b000010,  // alt selects srl, else sra
        op_slt    = 6'b000011,
        op_sltu   = 6'b000100,
        op_xor    = 6'b000101,
        op_or     = 6'b000110,
        op_and    = 6'b000111,
        op_mul    = 6'b001000,
        op_mulh   = 6'b001001,
        op_mulhsu = 6'b001010,
        op_mulhu  = 6'b001011,
        op_div    = 6'b001100,
        op_divu   = 6'b001101,
        op_rem    = 6'b001110,
        op_remu   = 6'b001111,
        op_addi   = 6'b100000,
        op_slli   = 6'b100001,
        op_sri    = 6'b100010,  // alt selects sra, else srl
        op_slti   = 6'b100011,
        op_sltiu  = 6'b100100,
        op_xori   = 6'b100101,
        op_ori    = 6'b100110,
        op_andi   = 6'b100111,
        op_lw     = 6'b101000,
        op_flw    = 6'b101001,
        op_lui    = 6'b101010,
        op_nop    = 6'b101011,
        op_beq    = 6'b110000,
        op_bne    = 6'b110001,
        op_blt    = 6'b110010,
        op_bge    = 6'b110011,
        op_bltu   = 6'b110100,
        op_bgeu   = 6'b110101,
        op_sw     = 6'b110110,
        op_fsw    = 6'b110111,
        op_jump   = 6'b111000,
        op_jal    = 6'b111001,
        op_jalr   = 6'b111010
    } alu_op_e;

    // first field lands in bit 6
    typedef struct packed {
        logic do_branch;
        logic geu;
        logic ltu;
        logic ge;
        logic lt;
        logic ne;
        logic eq;
    } br_mask_t;

    function automatic logic is_mul(alu_op_e op);
        return op inside {op_mul, op_mulh, op_mulhsu, op_mulhu};
    endfunction

endpackage

// File: exu_if.sv
`timescale 1ns/1ps

// one issued op, issue register to execute stage
interface exu_if import exu_pkg::*; ();

    alu_op_e       op;
    logic          alt;      // sub / shift variant select
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    br_mask_t      br_mask;
    logic          jump;

    modport issue_mp (
        output op, alt, op1, op2, br_mask, jump
    );

    modport exec_mp (
        input op, alt, op1, op2, br_mask, jump
    );

endinterface

// File: issue_stage.sv
`timescale 1ns/1ps

module issue_stage import exu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            advance,
    input  alu_op_e         op_in,
    input  logic            alt_in,
    input  logic [xlen-1:0] op1_in,
    input  logic [xlen-1:0] op2_in,
    input  br_mask_t        br_mask_in,
    input  logic            jump_in,
    exu_if.issue_mp         op_if
);

    always_ff @(posedge clk) begin
        if (rst) begin
            op_if.op      <= op_nop;   // empty slot after reset
            op_if.alt     <= 1'b0;
            op_if.op1     <= '0;
            op_if.op2     <= '0;
            op_if.br_mask <= '0;
            op_if.jump    <= 1'b0;
        end else if (advance) begin
            op_if.op      <= op_in;
            op_if.alt     <= alt_in;
            op_if.op1     <= op1_in;
            op_if.op2     <= op2_in;
            op_if.br_mask <= br_mask_in;
            op_if.jump    <= jump_in;
        end
        // otherwise hold, the op stays in execute
    end

endmodule

// File: int_alu.sv
`timescale 1ns/1ps

module int_alu import exu_pkg::*; (
    input  alu_op_e         op,
    input  logic            alt,
    input  logic [xlen-1:0] op1,
    input  logic [xlen-1:0] op2,
    input  logic [xlen-1:0] mul_res,
    output logic [xlen-1:0] result
);

    logic [4:0]      shamt;
    logic [xlen-1:0] add_r;
    logic [xlen-1:0] sub_r;
    logic [xlen-1:0] sll_r;
    logic [xlen-1:0] srl_r;
    logic [xlen-1:0] sra_r;
    logic [xlen-1:0] slt_r;
    logic [xlen-1:0] sltu_r;
    logic [xlen-1:0] xor_r;
    logic [xlen-1:0] or_r;
    logic [xlen-1:0] and_r;

    assign shamt  = op2[4:0];   // only low five bits shift
    assign add_r  = op1 + op2;
    assign sub_r  = op1 - op2;
    assign sll_r  = op1 << shamt;
    assign srl_r  = op1 >> shamt;
    assign sra_r  = $signed(op1) >>> shamt;
    assign slt_r  = {{(xlen-1){1'b0}}, $signed(op1) < $signed(op2)};
    assign sltu_r = {{(xlen-1){1'b0}}, op1 < op2};
    assign xor_r  = op1 ^ op2;
    assign or_r   = op1 | op2;
    assign and_r  = op1 & op2;

    always_comb begin
        case (op)
            op_add:    result = alt ? sub_r : add_r;
            op_sll:    result = sll_r;
            op_sr:     result = alt ? srl_r : sra_r;  // register group polarity
            op_slt:    result = slt_r;
            op_sltu:   result = sltu_r;
            op_xor:    result = xor_r;
            op_or:     result = or_r;
            op_and:    result = and_r;

            op_addi:   result = add_r;
            op_slli:   result = sll_r;
            op_sri:    result = alt ? sra_r : srl_r;  // immediate group is the other way
            op_slti:   result = slt_r;
            op_sltiu:  result = sltu_r;
            op_xori:   result = xor_r;
            op_ori:    result = or_r;
            op_andi:   result = and_r;

            op_mul, op_mulh, op_mulhsu, op_mulhu:
                       result = mul_res;

            op_lui, op_sw, op_fsw:
                       result = op2;
            op_jal, op_jalr:
                       result = add_r;         // link sum

            // division unimplemented, loads and control flow write nothing
            op_div, op_divu, op_rem, op_remu,
            op_lw, op_flw, op_nop,
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
            op_jump:   result = '0;
            default:   result = '0;            // unused codes
        endcase
    end

endmodule

// File: mul_unit.sv
`timescale 1ns/1ps

// shift-add multiplier, one 8-bit slice of op2 per cycle
// op1/op2 must stay stable until the last pass
module mul_unit import exu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  alu_op_e         op,
    input  logic [xlen-1:0] op1,
    input  logic [xlen-1:0] op2,
    output logic            busy,
    output logic [xlen-1:0] product
);

    logic                     go;
    logic                     run;
    logic                     hi_sel;
    logic                     last;
    logic [mul_step_w-1:0]    step;
    logic [mul_step_w-1:0]    idx;
    logic                     op1_signed;
    logic                     op2_signed;
    logic signed [mul_slice:0]    slice_s;  // slice plus sign bit
    logic signed [2*xlen-1:0] a_ext;
    logic signed [2*xlen-1:0] pp;
    logic [2*xlen-1:0]        acc;
    logic [2*xlen-1:0]        sum;
    logic [2*xlen-1:0]        full;

    assign go         = start && is_mul(op);
    assign last       = run && (step == mul_step_w'(mul_steps - 1));
    assign busy       = go || (run && !last);
    assign op1_signed = (op != op_mulhu);
    assign op2_signed = (op == op_mulh);

    always_comb begin
        idx   = go ? '0 : step;
        a_ext = op1_signed ? {{xlen{op1[xlen-1]}}, op1} : {{xlen{1'b0}}, op1};
        // only the top slice carries op2's sign weight
        slice_s = {op2_signed && (idx == mul_step_w'(mul_steps - 1))
                   && op2[idx*mul_slice + mul_slice - 1],
                   op2[idx*mul_slice +: mul_slice]};
        pp    = (a_ext * slice_s) <<< (idx * mul_slice);
        sum   = (go ? '0 : acc) + pp;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            run    <= 1'b0;
            step   <= '0;
            hi_sel <= 1'b0;
        end else if (go) begin
            run    <= 1'b1;
            step   <= mul_step_w'(1);
            hi_sel <= (op != op_mul);
        end else if (run) begin
            if (last)
                run <= 1'b0;
            step <= step + mul_step_w'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (go || run)
            acc <= sum;
    end

    // final pass shows up in the same cycle, then acc holds it
    assign full    = run ? sum : acc;
    assign product = hi_sel ? full[2*xlen-1:xlen] : full[xlen-1:0];

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage import exu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            advance,
    exu_if.exec_mp          op_if,
    output logic [xlen-1:0] wb_res,
    output logic [xlen-1:0] alu_fwd,
    output logic            alu_nstall,
    output logic            flush
);

    logic            mul_start;
    logic            mul_busy;
    logic            mul_launched;   // multiplier already taken this op
    logic [xlen-1:0] mul_res;
    logic [xlen-1:0] result;
    logic            eq;
    logic            lt;
    logic            ltu;
    logic            hit;

    assign mul_start = is_mul(op_if.op) && !mul_launched;

    // cleared when the op leaves, so a stalled product is not redone
    always_ff @(posedge clk) begin
        if (rst)
            mul_launched <= 1'b0;
        else if (advance)
            mul_launched <= 1'b0;
        else if (mul_start)
            mul_launched <= 1'b1;
    end

    mul_unit u_mul (
        .clk     (clk),
        .rst     (rst),
        .start   (mul_start),
        .op      (op_if.op),
        .op1     (op_if.op1),
        .op2     (op_if.op2),
        .busy    (mul_busy),
        .product (mul_res)
    );

    int_alu u_alu (
        .op      (op_if.op),
        .alt     (op_if.alt),
        .op1     (op_if.op1),
        .op2     (op_if.op2),
        .mul_res (mul_res),
        .result  (result)
    );

    assign alu_nstall = !mul_busy;
    assign alu_fwd    = result;      // unregistered forward

    // branch resolution
    assign eq  = (op_if.op1 == op_if.op2);
    assign lt  = $signed(op_if.op1) < $signed(op_if.op2);
    assign ltu = op_if.op1 < op_if.op2;
    assign hit = (op_if.br_mask.eq  &  eq)  | (op_if.br_mask.ne  & !eq)
               | (op_if.br_mask.lt  &  lt)  | (op_if.br_mask.ge  & !lt)
               | (op_if.br_mask.ltu &  ltu) | (op_if.br_mask.geu & !ltu);
    assign flush = (op_if.br_mask.do_branch & hit) | op_if.jump;

    always_ff @(posedge clk) begin
        if (rst)
            wb_res <= '0;
        else if (advance)
            wb_res <= result;
    end

endmodule

// File: exu_top.sv
`timescale 1ns/1ps

module exu_top import exu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            n_stall,
    input  alu_op_e         op,
    input  logic            alt,
    input  logic [xlen-1:0] op1,
    input  logic [xlen-1:0] op2,
    input  br_mask_t        br_mask,
    input  logic            jump,
    output logic [xlen-1:0] wb_res,
    output logic [xlen-1:0] alu_fwd,
    output logic            alu_nstall,
    output logic            flush
);

    logic advance;

    assign advance = n_stall & alu_nstall;  // external and multiplier stall

    exu_if u_if ();

    issue_stage u_issue (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .op_in      (op),
        .alt_in     (alt),
        .op1_in     (op1),
        .op2_in     (op2),
        .br_mask_in (br_mask),
        .jump_in    (jump),
        .op_if      (u_if.issue_mp)
    );

    execute_stage u_exec (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .op_if      (u_if.exec_mp),
        .wb_res     (wb_res),
        .alu_fwd    (alu_fwd),
        .alu_nstall (alu_nstall),
        .flush      (flush)
    );

endmodule

// File: tb_exu.sv
`timescale 1ns/1ps

module tb_exu import exu_pkg::*; ();

    localparam int num_pat   = 30;
    localparam int fields    = 9;   // hex words per pattern line
    localparam int max_stall = 6;
    localparam int limit     = num_pat * (mul_steps + max_stall + 2) + 20;

    logic            clk;
    logic            rst;
    logic            n_stall;
    alu_op_e         op;
    logic            alt;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    br_mask_t        br_mask;
    logic            jump;
    logic [xlen-1:0] wb_res;
    logic [xlen-1:0] alu_fwd;
    logic            alu_nstall;
    logic            flush;

    logic [31:0] pat_mem [0:num_pat*fields-1];
    int          cycles;

    exu_top u_exu_top (
        .clk        (clk),
        .rst        (rst),
        .n_stall    (n_stall),
        .op         (op),
        .alt        (alt),
        .op1        (op1),
        .op2        (op2),
        .br_mask    (br_mask),
        .jump       (jump),
        .wb_res     (wb_res),
        .alu_fwd    (alu_fwd),
        .alu_nstall (alu_nstall),
        .flush      (flush)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] exp);
        assert (got === exp) else
            abort_run($sformatf("[FAIL] %0t ns: %s expected %h, got %h",
                                $time, name, exp, got));
    endtask

    // past the last pattern a nop is driven to drain the pipeline
    task automatic apply_pattern(input int n, output logic [xlen-1:0] res,
                                 output logic fl, output logic is_mul_op,
                                 output int stall);
        int b;
        b = n * fields;
        if (n >= num_pat) begin
            op      = op_nop;
            alt     = 1'b0;
            op1     = '0;
            op2     = '0;
            br_mask = '0;
            jump    = 1'b0;
            res     = '0;
            fl      = 1'b0;
            stall   = 0;
        end else begin
            op      = alu_op_e'(pat_mem[b][5:0]);
            alt     = pat_mem[b+1][0];
            op1     = pat_mem[b+2];
            op2     = pat_mem[b+3];
            br_mask = br_mask_t'(pat_mem[b+4][6:0]);
            jump    = pat_mem[b+5][0];
            stall   = (pat_mem[b+6] == 0) ? 0 : 1 + int'($urandom % pat_mem[b+6]);
            res     = pat_mem[b+7];
            fl      = pat_mem[b+8][0];
        end
        is_mul_op = (op inside {op_mul, op_mulh, op_mulhsu, op_mulhu});
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        assert (cycles < limit) else
            abort_run($sformatf("timeout, no finish after %0d cycles", limit));
    end

    initial begin
        int              idx;
        int              accepted;
        int              stall_left;
        int              low_run;     // cycles with alu_nstall low for this op
        int unsigned     seed_val;
        logic            prev_acc;
        logic            exec_mul;
        logic            mul_done;
        logic            mul_next;
        logic            flush_exec;
        logic            flush_next;
        logic [xlen-1:0] exp_exec;
        logic [xlen-1:0] exp_next;
        logic [xlen-1:0] exp_wb;      // last value written back

        seed_val = $urandom(83);
        cycles   = 0;
        rst      = 1'b1;
        n_stall  = 1'b1;
        op       = op_nop;
        alt      = 1'b0;
        op1      = '0;
        op2      = '0;
        br_mask  = '0;
        jump     = 1'b0;
        $readmemh("exu_patterns.txt", pat_mem);
        assert (!$isunknown(pat_mem[num_pat*fields-1])) else
            abort_run("pattern file is missing or has too few lines");

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("wb_res", wb_res, '0);
        check_value("flush", xlen'(flush), '0);
        check_value("alu_nstall", xlen'(alu_nstall), xlen'(1));

        // the reset nop counts as the op in execute
        idx        = 0;
        accepted   = 0;
        stall_left = 0;
        low_run    = 0;
        prev_acc   = 1'b1;
        exec_mul   = 1'b0;
        mul_done   = 1'b0;
        mul_next   = 1'b0;
        flush_exec = 1'b0;
        flush_next = 1'b0;
        exp_exec   = '0;
        exp_next   = '0;
        exp_wb     = '0;

        while (accepted < num_pat + 2) begin
            if (prev_acc) begin
                accepted++;
                exp_wb = exp_exec;
                check_value("wb_res", wb_res, exp_wb);
                exp_exec   = exp_next;
                flush_exec = flush_next;
                exec_mul   = mul_next;
                mul_done   = 1'b0;
                low_run    = 0;
                apply_pattern(idx, exp_next, flush_next, mul_next, stall_left);
                idx++;
            end else begin
                check_value("wb_res", wb_res, exp_wb);  // held under stall
            end

            check_value("flush", xlen'(flush), xlen'(flush_exec));
            if (!alu_nstall) begin
                assert (exec_mul && !mul_done) else
                    abort_run($sformatf("alu_nstall low at %0t ns with no multiply pending",
                                        $time));
                low_run++;
            end else begin
                assert (!exec_mul || mul_done || low_run != 0) else
                    abort_run("multiply in execute did not stall the pipeline");
                if (low_run != 0) begin
                    check_value("alu_nstall low cycles", xlen'(low_run),
                                xlen'(mul_steps - 1));
                    low_run  = 0;
                    mul_done = 1'b1;
                end
                check_value("alu_fwd", alu_fwd, exp_exec);
            end

            if (stall_left > 0) begin
                n_stall    = 1'b0;
                stall_left = stall_left - 1;
            end else begin
                n_stall = 1'b1;
            end
            prev_acc = n_stall & alu_nstall;  // decides the coming edge
            @(negedge clk);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: exu_patterns.txt
// op alt op1 op2 br_mask jump stall exp_res exp_flush, all hex
// stall is the upper bound of a random n_stall gap before issue, 0 for none
00 0 00000005 00000003 00 0 0 00000008 0
00 1 00000005 00000007 00 0 0 fffffffe 0
01 0 80000001 00000024 00 0 3 00000010 0 // shift 36 uses 4
02 0 80000000 0000001f 00 0 0 ffffffff 0
02 1 80000000 0000003f 00 0 0 00000001 0
03 0 ffffffff 00000001 00 0 0 00000001 0
04 0 ffffffff 00000001 00 0 0 00000000 0
05 0 f0f0f0f0 0ff00ff0 00 0 0 ff00ff00 0
20 1 ffffffff 00000001 00 0 0 00000000 0
22 1 f0000000 00000004 00 0 0 ff000000 0
21 0 00000003 0000001f 00 0 0 80000000 0
2a 0 deadbeef 12345000 00 0 0 12345000 0
36 0 00001000 cafef00d 00 0 0 cafef00d 0
39 0 00000100 00000004 00 1 0 00000104 1
3a 0 00002000 fffffffc 00 1 0 00001ffc 1
0c 0 00000064 00000005 00 0 0 00000000 0
3f 0 12345678 87654321 00 0 0 00000000 0 // unused code
08 0 00000007 fffffffd 00 0 0 ffffffeb 0
09 0 80000000 80000000 00 0 5 40000000 0 // stalled while mul runs
0a 0 ffffffff ffffffff 00 0 0 ffffffff 0
0b 0 ffffffff ffffffff 00 0 0 fffffffe 0
00 0 00000010 00000020 00 0 6 00000030 0 // stall past mulhu completion
30 0 00000005 00000005 41 0 0 00000000 1
31 0 00000005 00000005 42 0 0 00000000 0
32 0 ffffffff 00000001 44 0 0 00000000 1
33 0 ffffffff 00000001 48 0 0 00000000 0
34 0 ffffffff 00000001 50 0 0 00000000 0
35 0 ffffffff 00000001 60 0 0 00000000 1
30 0 00000005 00000005 01 0 0 00000000 0
38 0 00000000 00000000 00 1 2 00000000 1

// File: tb.f
exu_pkg.sv
exu_if.sv
issue_stage.sv
int_alu.sv
mul_unit.sv
execute_stage.sv
exu_top.sv
tb_exu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the execute unit testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_exu -o tb_exu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_exu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
fi
exit $status
